/* all.f */
hdl/alu_pkg.sv
hdl/alu_adder.sv
hdl/alu_shifter.sv
hdl/leading_run_counter.sv
hdl/alu_bit_count.sv
hdl/alu_bitwise.sv
hdl/alu_exec_stage.sv
bench/alu_checker.sv
bench/tb_alu_exec_stage.sv

/* bench/alu_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_checker (
  input wire                   clk,
  input wire                   rst_n,
  input wire                   op_valid,
  input wire alu_pkg::alu_op_t alu_op,
  input wire  [31:0]           a,
  input wire  [31:0]           b,
  input wire                   count_ones,
  input wire  [31:0]           result,
  input wire                   result_valid
);

  import alu_pkg::*;

  localparam int drain_limit = 50;

  logic [31:0] expected_q[$];
  logic [4:0]  op_q[$];
  logic [31:0] expected_value;
  logic [4:0]  expected_op;
  logic [31:0] held_result = '0;
  logic        last_op_valid = 1'b0;
  int          reset_edges = 0;
  int          error_count = 0;
  int          check_count = 0;
  int          test_count = 0;
  int          test_start_errors = 0;
  int          test_start_checks = 0;

  function automatic logic [31:0] expected_result(input alu_op_t op, input logic [31:0] x,
                                                  input logic [31:0] y, input logic ones);
    logic [31:0] r;
    logic        run;
    int          s;
    s = y[4:0];
    r = '0;
    run = 1'b1;
    case (op)
      op_add:    r = x + y;
      op_sub:    r = x - y;
      op_slt:    r = {31'b0, $signed(x) < $signed(y)};
      op_sltu:   r = {31'b0, x < y};
      op_and:    r = x & y;
      op_andn:   r = x & ~y;
      op_or:     r = x | y;
      op_orn:    r = x | ~y;
      op_xor:    r = x ^ y;
      op_nor:    r = ~(x | y);
      op_sll:    r = x << s;
      op_srl:    r = x >> s;
      op_sra:    r = $signed(x) >>> s;
      op_rotr:   r = (x >> s) | (x << (32 - s));
      op_count_lead: begin
        for (int i = 31; i >= 0; i--) begin
          run = run && (x[i] == ones);
          r = r + run;
        end
      end
      op_count_tail: begin
        for (int i = 0; i < 32; i++) begin
          run = run && (x[i] == ones);
          r = r + run;
        end
      end
      op_bitrev: begin
        for (int i = 0; i < 32; i++) begin
          r[i] = x[31-i];
        end
      end
      op_revb:   r = {x[7:0], x[15:8], x[23:16], x[31:24]};
      op_seb:    r = {{24{x[7]}}, x[7:0]};
      op_seh:    r = {{16{x[15]}}, x[15:0]};
      op_seleqz: r = (y == 32'd0) ? x : 32'd0;
      op_selnez: r = (y != 32'd0) ? x : 32'd0;
      op_lu12i:  r = y;
      default:   r = '0;
    endcase
    return r;
  endfunction

  // inputs and outputs both settle after the edge, so pre-edge values line up
  always @(posedge clk) begin
    if (!rst_n) begin
      if (reset_edges > 0 && result_valid !== 1'b0) begin
        $display("FAILED at %0t: result_valid %b during reset", $time, result_valid);
        error_count++;
      end
      reset_edges++;
      last_op_valid = 1'b0;
      held_result = '0;
    end else begin
      if (result_valid !== last_op_valid) begin
        $display("FAILED at %0t: result_valid %b, expected %b", $time, result_valid,
                 last_op_valid);
        error_count++;
      end
      if (result_valid === 1'b1) begin
        if (expected_q.size() == 0) begin
          $display("result_valid arrived with no operation pending at time %0t", $time);
          error_count++;
        end else begin
          expected_value = expected_q.pop_front();
          expected_op = op_q.pop_front();
          check_count++;
          if (result !== expected_value) begin
            $display("FAILED at %0t: op %0d result %h, expected %h", $time, expected_op,
                     result, expected_value);
            error_count++;
          end
          held_result = expected_value;
        end
      end else if (result !== held_result) begin
        // idle cycles keep the last result, zero since reset
        $display("FAILED at %0t: idle result %h, expected held %h", $time, result,
                 held_result);
        error_count++;
      end
      if (op_valid === 1'b1) begin
        expected_q.push_back(expected_result(alu_op, a, b, count_ones));
        op_q.push_back(alu_op);
      end
      last_op_valid = (op_valid === 1'b1);
    end
  end

  task automatic end_test(input string name);
    int waited;
    waited = 0;
    @(negedge clk);
    while (expected_q.size() != 0 && waited < drain_limit) begin
      @(negedge clk);
      waited++;
    end
    if (expected_q.size() != 0) begin
      $display("test %s: %0d expected results never arrived", name, expected_q.size());
      error_count++;
      expected_q.delete();
      op_q.delete();
    end
    test_count++;
    $display("test %s done: %0d checks, %0d errors", name, check_count - test_start_checks,
             error_count - test_start_errors);
    test_start_errors = error_count;
    test_start_checks = check_count;
  endtask

  task automatic report_totals();
    $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
  endtask

endmodule

`default_nettype wire

/* bench/tb_alu_exec_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_alu_exec_stage;

  import alu_pkg::*;

  localparam int          data_width = 32;
  localparam logic [31:0] lfsr_seed = 32'h6bc5;
  localparam int          random_ops = 40;

  logic        clk;
  logic        rst_n;
  logic        op_valid;
  alu_op_t     alu_op;
  logic [31:0] a;
  logic [31:0] b;
  logic        count_ones;
  logic [31:0] result;
  logic        result_valid;
  logic [31:0] lfsr_state = lfsr_seed;

  logic [31:0] edge_values [6] = '{32'h0, 32'h1, 32'h7fff_ffff, 32'h8000_0000,
                                   32'hffff_ffff, 32'h1234_5678};
  alu_op_t     bitwise_ops [13] = '{op_and, op_andn, op_or, op_orn, op_xor, op_nor,
                                    op_bitrev, op_revb, op_seb, op_seh, op_lu12i,
                                    op_seleqz, op_selnez};

  alu_exec_stage #(.data_width(data_width)) alu_exec_stage_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .op_valid     (op_valid),
    .alu_op       (alu_op),
    .a            (a),
    .b            (b),
    .count_ones   (count_ones),
    .result       (result),
    .result_valid (result_valid)
  );

  alu_checker checker_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .op_valid     (op_valid),
    .alu_op       (alu_op),
    .a            (a),
    .b            (b),
    .count_ones   (count_ones),
    .result       (result),
    .result_valid (result_valid)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  task automatic random_bits(input int count, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = {value[30:0], lfsr_state[0]};
    end
  endtask

  task automatic issue_op(input alu_op_t op, input logic [31:0] op_a, input logic [31:0] op_b,
                          input logic ones, input bit gaps);
    logic [31:0] r;
    @(posedge clk);
    op_valid <= 1'b1;
    alu_op <= op;
    a <= op_a;
    b <= op_b;
    count_ones <= ones;
    if (gaps) begin
      random_bits(2, r);
      // idle cycle about one time in four
      if (r[1:0] == 2'b00) begin
        @(posedge clk);
        op_valid <= 1'b0;
      end
    end
  endtask

  task automatic finish_test(input string name);
    @(posedge clk);
    op_valid <= 1'b0;
    checker_i.end_test(name);
  endtask

  initial begin
    logic [31:0] ra;
    logic [31:0] rb;
    logic [31:0] rc;
    alu_op_t     op;
    rst_n = 1'b0;
    op_valid = 1'b0;
    alu_op = op_add;
    a = '0;
    b = '0;
    count_ones = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    // idle first, then back to back, then gapped
    repeat (4) @(posedge clk);
    for (int i = 0; i < 32; i++) begin
      random_bits(32, ra);
      random_bits(32, rb);
      issue_op(i < 16 ? op_add : op_sub, ra, rb, 1'b0, i >= 16);
    end
    finish_test("reset_valid");

    // codes 0 to 3 are add, sub, slt, sltu
    for (int k = 0; k < 4; k++) begin
      op = alu_op_t'(k);
      for (int i = 0; i < 6; i++) begin
        for (int j = 0; j < 6; j++) begin
          issue_op(op, edge_values[i], edge_values[j], 1'b0, 1'b1);
        end
      end
      for (int n = 0; n < random_ops; n++) begin
        random_bits(32, ra);
        random_bits(32, rb);
        issue_op(op, ra, rb, 1'b0, 1'b1);
      end
    end
    finish_test("arithmetic");

    for (int k = op_sll; k <= op_rotr; k++) begin
      for (int s = 0; s < 32; s++) begin
        random_bits(32, ra);
        random_bits(27, rb);
        ra[31] = ra[31] | s[0];
        issue_op(alu_op_t'(k), ra, {rb[26:0], 5'(s)}, 1'b0, 1'b1);
      end
    end
    finish_test("shifts");

    for (int k = op_count_lead; k <= op_count_tail; k++) begin
      for (int ones = 0; ones < 2; ones++) begin
        op = alu_op_t'(k);
        issue_op(op, 32'h0, 32'h0, ones[0], 1'b1);
        issue_op(op, 32'hffff_ffff, 32'h0, ones[0], 1'b1);
        for (int i = 0; i < 32; i++) begin
          issue_op(op, 32'h1 << i, 32'h0, ones[0], 1'b1);
          issue_op(op, ~(32'h1 << i), 32'h0, ones[0], 1'b1);
        end
        for (int n = 0; n < 8; n++) begin
          random_bits(32, ra);
          issue_op(op, ra, 32'h0, ones[0], 1'b1);
        end
      end
    end
    finish_test("counts");

    for (int k = 0; k < 13; k++) begin
      for (int n = 0; n < random_ops / 2; n++) begin
        random_bits(32, ra);
        random_bits(32, rb);
        random_bits(1, rc);
        if ((bitwise_ops[k] == op_seleqz || bitwise_ops[k] == op_selnez) && rc[0]) begin
          rb = '0;
        end
        issue_op(bitwise_ops[k], ra, rb, rc[0], 1'b1);
      end
    end
    // undefined codes
    for (int code = 23; code < 32; code++) begin
      random_bits(32, ra);
      random_bits(32, rb);
      issue_op(alu_op_t'(code), ra, rb, 1'b0, 1'b1);
    end
    finish_test("bitwise");

    checker_i.report_totals();
    if (checker_i.error_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/alu_adder.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_adder #(
  parameter int data_width = alu_pkg::default_data_width
) (
  input  wire  [data_width-1:0] a,
  input  wire  [data_width-1:0] b,
  input  wire                   subtract,
  output logic [data_width-1:0] sum,
  output logic                  less_signed,
  output logic                  less_unsigned
);

  logic [data_width-1:0] addend;
  logic                  carry;
  logic                  overflow;

  // subtract as a + ~b + 1
  assign addend = subtract ? ~b : b;

  assign {carry, sum} = {1'b0, a} + {1'b0, addend}
                        + {{data_width{1'b0}}, subtract};

  // signs of both inputs and the output, with the carry into the msb folded in
  assign overflow = a[data_width-1] ^ addend[data_width-1]
                    ^ carry ^ sum[data_width-1];

  assign less_signed = sum[data_width-1] ^ overflow;

  // no borrow out means a >= b
  assign less_unsigned = ~carry;

endmodule

`default_nettype wire

/* hdl/alu_bit_count.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_bit_count #(
  parameter int data_width = alu_pkg::default_data_width
) (
  input  wire  [data_width-1:0] a,
  input  wire                   count_ones,
  input  wire                   trailing,
  output logic [data_width-1:0] count_result
);

  localparam int count_width = $clog2(data_width) + 1;

  logic [data_width-1:0]  reversed;
  logic [data_width-1:0]  counter_input;
  logic [count_width-1:0] count;

  for (genvar i = 0; i < data_width; i++) begin : g_rev
    assign reversed[i] = a[data_width-1-i];
  end

  // trailing run of a is the leading run of its mirror
  assign counter_input = trailing ? reversed : a;

  leading_run_counter #(.width(data_width)) counter_i (
    .number     (counter_input),
    .count_ones (count_ones),
    .count      (count)
  );

  assign count_result = {{(data_width-count_width){1'b0}}, count};

endmodule

`default_nettype wire

/* hdl/alu_bitwise.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_bitwise #(
  parameter int data_width = alu_pkg::default_data_width
) (
  input  wire  [data_width-1:0] a,
  input  wire  [data_width-1:0] b,
  output logic [data_width-1:0] and_result,
  output logic [data_width-1:0] andn_result,
  output logic [data_width-1:0] or_result,
  output logic [data_width-1:0] orn_result,
  output logic [data_width-1:0] xor_result,
  output logic [data_width-1:0] nor_result,
  output logic [data_width-1:0] bitrev_result,
  output logic [data_width-1:0] revb_result,
  output logic [data_width-1:0] seb_result,
  output logic [data_width-1:0] seh_result,
  output logic [data_width-1:0] seleqz_result,
  output logic [data_width-1:0] selnez_result
);

  import alu_pkg::*;

  localparam int num_bytes = data_width / byte_width;
  localparam int half_width = 2 * byte_width;

  logic b_zero;

  for (genvar byte_idx = 0; byte_idx < num_bytes; byte_idx++) begin : g_byte
    localparam int lo = byte_idx * byte_width;
    localparam int mirror_lo = (num_bytes - 1 - byte_idx) * byte_width;

    assign and_result[lo +: byte_width]  = a[lo +: byte_width] & b[lo +: byte_width];
    assign andn_result[lo +: byte_width] = a[lo +: byte_width] & ~b[lo +: byte_width];
    assign or_result[lo +: byte_width]   = a[lo +: byte_width] | b[lo +: byte_width];
    assign orn_result[lo +: byte_width]  = a[lo +: byte_width] | ~b[lo +: byte_width];
    assign xor_result[lo +: byte_width]  = a[lo +: byte_width] ^ b[lo +: byte_width];
    assign nor_result[lo +: byte_width]  = ~(a[lo +: byte_width] | b[lo +: byte_width]);

    // bytes swap end for end, bits inside keep order
    assign revb_result[lo +: byte_width] = a[mirror_lo +: byte_width];

    // mirror byte with its bits flipped
    for (genvar bit_idx = 0; bit_idx < byte_width; bit_idx++) begin : g_bit
      assign bitrev_result[lo + bit_idx] = a[mirror_lo + byte_width - 1 - bit_idx];
    end
  end

  assign seb_result = {{(data_width-byte_width){a[byte_width-1]}}, a[byte_width-1:0]};
  assign seh_result = {{(data_width-half_width){a[half_width-1]}}, a[half_width-1:0]};

  assign b_zero = (b == '0);

  assign seleqz_result = b_zero ? a : '0;
  assign selnez_result = b_zero ? '0 : a;

endmodule

`default_nettype wire

/* hdl/alu_exec_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_exec_stage #(
  parameter int data_width = alu_pkg::default_data_width
) (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   op_valid,
  input  wire alu_pkg::alu_op_t alu_op,
  input  wire  [data_width-1:0] a,
  input  wire  [data_width-1:0] b,
  input  wire                   count_ones,
  output logic [data_width-1:0] result,
  output logic                  result_valid
);

  import alu_pkg::*;

  // one-hot decode
  logic sel_add;
  logic sel_sub;
  logic sel_slt;
  logic sel_sltu;
  logic sel_and;
  logic sel_andn;
  logic sel_or;
  logic sel_orn;
  logic sel_xor;
  logic sel_nor;
  logic sel_sll;
  logic sel_srl;
  logic sel_sra;
  logic sel_rotr;
  logic sel_count;
  logic sel_bitrev;
  logic sel_revb;
  logic sel_seb;
  logic sel_seh;
  logic sel_seleqz;
  logic sel_selnez;
  logic sel_lu12i;

  logic subtract;
  logic trailing;

  logic [data_width-1:0] sum;
  logic                  less_signed;
  logic                  less_unsigned;
  logic [data_width-1:0] sll_result;
  logic [data_width-1:0] srl_result;
  logic [data_width-1:0] sra_result;
  logic [data_width-1:0] rotr_result;
  logic [data_width-1:0] count_result;
  logic [data_width-1:0] and_result;
  logic [data_width-1:0] andn_result;
  logic [data_width-1:0] or_result;
  logic [data_width-1:0] orn_result;
  logic [data_width-1:0] xor_result;
  logic [data_width-1:0] nor_result;
  logic [data_width-1:0] bitrev_result;
  logic [data_width-1:0] revb_result;
  logic [data_width-1:0] seb_result;
  logic [data_width-1:0] seh_result;
  logic [data_width-1:0] seleqz_result;
  logic [data_width-1:0] selnez_result;
  logic [data_width-1:0] next_result;

  assign sel_add    = (alu_op == op_add);
  assign sel_sub    = (alu_op == op_sub);
  assign sel_slt    = (alu_op == op_slt);
  assign sel_sltu   = (alu_op == op_sltu);
  assign sel_and    = (alu_op == op_and);
  assign sel_andn   = (alu_op == op_andn);
  assign sel_or     = (alu_op == op_or);
  assign sel_orn    = (alu_op == op_orn);
  assign sel_xor    = (alu_op == op_xor);
  assign sel_nor    = (alu_op == op_nor);
  assign sel_sll    = (alu_op == op_sll);
  assign sel_srl    = (alu_op == op_srl);
  assign sel_sra    = (alu_op == op_sra);
  assign sel_rotr   = (alu_op == op_rotr);
  assign sel_count  = (alu_op == op_count_lead) | (alu_op == op_count_tail);
  assign sel_bitrev = (alu_op == op_bitrev);
  assign sel_revb   = (alu_op == op_revb);
  assign sel_seb    = (alu_op == op_seb);
  assign sel_seh    = (alu_op == op_seh);
  assign sel_seleqz = (alu_op == op_seleqz);
  assign sel_selnez = (alu_op == op_selnez);
  assign sel_lu12i  = (alu_op == op_lu12i);

  // compares run through the subtractor
  assign subtract = sel_sub | sel_slt | sel_sltu;
  assign trailing = (alu_op == op_count_tail);

  alu_adder #(.data_width(data_width)) adder_i (
    .a             (a),
    .b             (b),
    .subtract      (subtract),
    .sum           (sum),
    .less_signed   (less_signed),
    .less_unsigned (less_unsigned)
  );

  alu_shifter #(.data_width(data_width)) shifter_i (
    .a           (a),
    .b           (b),
    .sll_result  (sll_result),
    .srl_result  (srl_result),
    .sra_result  (sra_result),
    .rotr_result (rotr_result)
  );

  alu_bit_count #(.data_width(data_width)) bit_count_i (
    .a            (a),
    .count_ones   (count_ones),
    .trailing     (trailing),
    .count_result (count_result)
  );

  alu_bitwise #(.data_width(data_width)) bitwise_i (
    .a             (a),
    .b             (b),
    .and_result    (and_result),
    .andn_result   (andn_result),
    .or_result     (or_result),
    .orn_result    (orn_result),
    .xor_result    (xor_result),
    .nor_result    (nor_result),
    .bitrev_result (bitrev_result),
    .revb_result   (revb_result),
    .seb_result    (seb_result),
    .seh_result    (seh_result),
    .seleqz_result (seleqz_result),
    .selnez_result (selnez_result)
  );

  // and-or mux, undefined codes select nothing
  assign next_result =
      {data_width{sel_add | sel_sub}} & sum |
      {data_width{sel_slt}}    & {{(data_width-1){1'b0}}, less_signed} |
      {data_width{sel_sltu}}   & {{(data_width-1){1'b0}}, less_unsigned} |
      {data_width{sel_and}}    & and_result |
      {data_width{sel_andn}}   & andn_result |
      {data_width{sel_or}}     & or_result |
      {data_width{sel_orn}}    & orn_result |
      {data_width{sel_xor}}    & xor_result |
      {data_width{sel_nor}}    & nor_result |
      {data_width{sel_sll}}    & sll_result |
      {data_width{sel_srl}}    & srl_result |
      {data_width{sel_sra}}    & sra_result |
      {data_width{sel_rotr}}   & rotr_result |
      {data_width{sel_count}}  & count_result |
      {data_width{sel_bitrev}} & bitrev_result |
      {data_width{sel_revb}}   & revb_result |
      {data_width{sel_seb}}    & seb_result |
      {data_width{sel_seh}}    & seh_result |
      {data_width{sel_seleqz}} & seleqz_result |
      {data_width{sel_selnez}} & selnez_result |
      {data_width{sel_lu12i}}  & b;

  // result holds between valid operations
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result       <= '0;
      result_valid <= 1'b0;
    end else begin
      result_valid <= op_valid;
      if (op_valid) begin
        result <= next_result;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/alu_pkg.sv */
`default_nettype none

package alu_pkg;

  localparam int alu_op_width = 5;

  // operand width unless the top level overrides it
  localparam int default_data_width = 32;

  localparam int byte_width = 8;

  // codes 23 to 31 are undefined and give a zero result
  typedef enum logic [alu_op_width-1:0] {
    op_add        = 5'd0,
    op_sub        = 5'd1,
    op_slt        = 5'd2,
    op_sltu       = 5'd3,
    op_and        = 5'd4,
    op_andn       = 5'd5,
    op_or         = 5'd6,
    op_orn        = 5'd7,
    op_xor        = 5'd8,
    op_nor        = 5'd9,
    op_sll        = 5'd10,
    op_srl        = 5'd11,
    op_sra        = 5'd12,
    op_rotr       = 5'd13,
    op_count_lead = 5'd14,
    op_count_tail = 5'd15,
    op_bitrev     = 5'd16,
    op_revb       = 5'd17,
    op_seb        = 5'd18,
    op_seh        = 5'd19,
    op_seleqz     = 5'd20,
    op_selnez     = 5'd21,
    op_lu12i      = 5'd22
  } alu_op_t;

endpackage

`default_nettype wire

/* hdl/alu_shifter.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_shifter #(
  parameter int data_width = alu_pkg::default_data_width
) (
  input  wire  [data_width-1:0] a,
  input  wire  [data_width-1:0] b,
  output logic [data_width-1:0] sll_result,
  output logic [data_width-1:0] srl_result,
  output logic [data_width-1:0] sra_result,
  output logic [data_width-1:0] rotr_result
);

  localparam int shamt_width = $clog2(data_width);

  logic [shamt_width-1:0]  shamt;
  logic [2*data_width-1:0] sra_wide;
  logic [2*data_width-1:0] rot_wide;

  // upper bits of b ignored
  assign shamt = b[shamt_width-1:0];

  assign sll_result = a << shamt;
  assign srl_result = a >> shamt;

  // sign copies above a so the shift pulls them in
  assign sra_wide   = {{data_width{a[data_width-1]}}, a} >> shamt;
  assign sra_result = sra_wide[data_width-1:0];

  // low bits of the upper copy wrap into the top
  assign rot_wide    = {a, a} >> shamt;
  assign rotr_result = rot_wide[data_width-1:0];

endmodule

`default_nettype wire

/* hdl/leading_run_counter.sv */
`timescale 1ns/100ps
`default_nettype none

module leading_run_counter #(
  parameter int width = alu_pkg::default_data_width
) (
  input  wire  [width-1:0]      number,
  input  wire                   count_ones,
  output logic [$clog2(width):0] count
);

  if (width == 4) begin : g_leaf
    logic [3:0] match;

    // ones where the bit equals the counted value
    assign match = count_ones ? number : ~number;

    always_comb begin
      if (match == 4'b1111)
        count = 3'd4;
      else if (match[3:1] == 3'b111)
        count = 3'd3;
      else if (match[3:2] == 2'b11)
        count = 3'd2;
      else if (match[3])
        count = 3'd1;
      else
        count = 3'd0;
    end
  end else begin : g_node
    localparam int half = width / 2;
    localparam int half_count_width = $clog2(half) + 1;

    logic [half_count_width-1:0] upper_count;
    logic [half_count_width-1:0] lower_count;

    leading_run_counter #(.width(half)) upper_i (
      .number     (number[width-1:half]),
      .count_ones (count_ones),
      .count      (upper_count)
    );

    leading_run_counter #(.width(half)) lower_i (
      .number     (number[half-1:0]),
      .count_ones (count_ones),
      .count      (lower_count)
    );

    // lower half only counts when the run covers the whole upper half
    assign count = (upper_count == half_count_width'(half))
                   ? {1'b0, upper_count} + {1'b0, lower_count}
                   : {1'b0, upper_count};
  end

endmodule

`default_nettype wire
